//--- source/mem_stage_pkg.sv
package mem_stage_pkg;

    ////////////////////////////////////////////////////////////
    // Datapath widths
    ////////////////////////////////////////////////////////////

    localparam int WORD_SIZE = 32;  // Data word
    localparam int REG_SEL   = 5;   // Destination register select
    localparam int ADDR_SIZE = 10;  // Instruction address (PC)

    // Access size of a load or store
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10       // 2'b11 unused, treated as word
    } size_e;

    ////////////////////////////////////////////////////////////
    // Records
    ////////////////////////////////////////////////////////////

    // One instruction entering the memory stage
    typedef struct packed {
        logic [ADDR_SIZE-1:0] branch_target;  // PC of branch target
        logic [WORD_SIZE-1:0] alu_result;     // Also the load/store address
        logic [WORD_SIZE-1:0] write_data;     // Store data
        logic [REG_SEL-1:0]   rd;             // Writeback register
        logic                 alu_zero;       // Branch condition
        logic                 branch;
        logic                 jump;
        logic                 mem_read;
        logic                 mem_write;
        logic                 reg_write;
        logic                 data_sign;      // Sign-extend narrow loads
        size_e                data_size;
    } ex_mem_t;

    // RAM word, split into byte lanes or halfword lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;   // Lane 0 is the low byte
        logic [1:0][15:0] halves;
    } mem_word_u;

    // Writeback record
    typedef struct packed {
        logic [REG_SEL-1:0]   rd;
        logic                 reg_write;
        logic [WORD_SIZE-1:0] data;
    } wb_t;

    // PC redirect record
    typedef struct packed {
        logic                 taken;
        logic [ADDR_SIZE-1:0] target;
    } redirect_t;

endpackage

//--- source/ex_mem_reg.sv
`timescale 1ns/1ps

module ex_mem_reg import mem_stage_pkg::*; #(
    parameter int WB_CREDITS = 4
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    flush,
    input  logic    in_valid,
    input  ex_mem_t in_instr,
    input  logic    credit_return,
    output logic    in_ready,
    output logic    stage_valid,
    output ex_mem_t stage_instr
);

    localparam int CNT_W = $clog2(WB_CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;   // Free slots in writeback
    logic [CNT_W-1:0] credit_next;
    logic             held_valid;   // Registered valid bit
    logic             accept;
    logic             refund;       // Flush killed a held instruction

    ////////////////////////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////////////////////////

    assign in_ready = (credit_cnt != '0);
    assign accept   = in_valid & in_ready & ~flush;  // Flush blocks acceptance
    assign refund   = flush & held_valid;

    // Held instruction dies in the flush cycle, so no store and no output
    assign stage_valid = held_valid & ~flush;

    ////////////////////////////////////////////////////////////
    // Credit counter
    ////////////////////////////////////////////////////////////

    always_comb begin
        credit_next = credit_cnt;
        if (accept)
            credit_next = credit_next - CNT_W'(1);   // Slot now owned by this instr
        if (credit_return)
            credit_next = credit_next + CNT_W'(1);
        if (refund)
            credit_next = credit_next + CNT_W'(1);   // Discarded instr gives slot back
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credit_cnt <= CNT_W'(WB_CREDITS);
            held_valid <= 1'b0;
        end else begin
            credit_cnt <= credit_next;
            held_valid <= accept;   // Drops on flush or idle input
        end
    end

    // Payload only, qualified by held_valid
    always_ff @(posedge clk) begin
        if (accept)
            stage_instr <= in_instr;
    end

endmodule

//--- source/branch_resolve.sv
`timescale 1ns/1ps

module branch_resolve import mem_stage_pkg::*; (
    input  logic      stage_valid,
    input  ex_mem_t   stage_instr,
    output redirect_t redirect
);

    logic cond_taken;   // Jump, or branch with zero result

    ////////////////////////////////////////////////////////////
    // Branch rule
    ////////////////////////////////////////////////////////////

    // Unconditional jump always redirects
    // Branch redirects only when the compare came out zero
    assign cond_taken = stage_instr.jump
                      | (stage_instr.branch & stage_instr.alu_zero);

    always_comb begin
        redirect.taken  = stage_valid & cond_taken;
        redirect.target = '0;                         // Quiet when not taken
        if (redirect.taken)
            redirect.target = stage_instr.branch_target;
    end

endmodule

//--- source/data_mem_access.sv
`timescale 1ns/1ps

module data_mem_access import mem_stage_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 stage_valid,
    input  ex_mem_t              stage_instr,
    output logic [WORD_SIZE-1:0] load_data
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [WORD_SIZE-1:0] ram [MEM_WORDS];   // Data RAM, no init

    logic [IDX_W-1:0] word_idx;
    logic [1:0]       byte_off;     // Lane select
    logic             wr_en;
    mem_word_u        rd_word;      // Current word at word_idx
    mem_word_u        wr_word;      // Merged store word
    logic [7:0]       byte_lane;
    logic [15:0]      half_lane;

    ////////////////////////////////////////////////////////////
    // Address split
    ////////////////////////////////////////////////////////////

    // Upper address bits wrap modulo MEM_WORDS
    assign word_idx = stage_instr.alu_result[IDX_W+1:2];
    assign byte_off = stage_instr.alu_result[1:0];

    // Asynchronous read
    assign rd_word = ram[word_idx];

    ////////////////////////////////////////////////////////////
    // Store path
    ////////////////////////////////////////////////////////////

    assign wr_en = stage_valid & stage_instr.mem_write;

    // Read-modify-write of one lane
    always_comb begin
        wr_word = rd_word;
        case (stage_instr.data_size)
            SIZE_BYTE: begin
                wr_word.bytes[byte_off] = stage_instr.write_data[7:0];
            end
            SIZE_HALF: begin
                // Low address bit ignored
                wr_word.halves[byte_off[1]] = stage_instr.write_data[15:0];
            end
            default: begin
                wr_word = stage_instr.write_data;   // Whole word
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            ram[word_idx] <= wr_word;
    end

    ////////////////////////////////////////////////////////////
    // Load path
    ////////////////////////////////////////////////////////////

    assign byte_lane = rd_word.bytes[byte_off];
    assign half_lane = rd_word.halves[byte_off[1]];

    always_comb begin
        case (stage_instr.data_size)
            SIZE_BYTE: begin
                // Sign bit replicated only for signed loads
                load_data = {{24{stage_instr.data_sign & byte_lane[7]}}, byte_lane};
            end
            SIZE_HALF: begin
                load_data = {{16{stage_instr.data_sign & half_lane[15]}}, half_lane};
            end
            default: begin
                load_data = rd_word;
            end
        endcase
    end

endmodule

//--- source/mem_wb_out.sv
`timescale 1ns/1ps

module mem_wb_out import mem_stage_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 stage_valid,
    input  ex_mem_t              stage_instr,
    input  redirect_t            redirect,
    input  logic [WORD_SIZE-1:0] load_data,
    output logic                 out_valid,
    output wb_t                  out_wb,
    output redirect_t            out_redirect
);

    wb_t                  wb_next;
    logic                 taken_q;
    logic [ADDR_SIZE-1:0] target_q;

    ////////////////////////////////////////////////////////////
    // Writeback select
    ////////////////////////////////////////////////////////////

    always_comb begin
        wb_next.rd        = stage_instr.rd;
        wb_next.reg_write = stage_instr.reg_write;   // Passed through as is
        wb_next.data      = stage_instr.alu_result;
        if (stage_instr.mem_read)
            wb_next.data = load_data;               // Loads return memory data
    end

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    // Control bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            taken_q   <= 1'b0;
        end else begin
            out_valid <= stage_valid;
            taken_q   <= redirect.taken;   // Already gated by stage_valid
        end
    end

    // Payload, only updated for live instructions
    always_ff @(posedge clk) begin
        if (stage_valid) begin
            out_wb   <= wb_next;
            target_q <= redirect.target;
        end
    end

    assign out_redirect.taken  = taken_q;
    assign out_redirect.target = target_q;

endmodule

//--- source/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top import mem_stage_pkg::*; #(
    parameter int MEM_WORDS  = 256,
    parameter int WB_CREDITS = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    input  logic      in_valid,
    input  ex_mem_t   in_instr,
    output logic      in_ready,
    input  logic      credit_return,
    output logic      out_valid,
    output wb_t       out_wb,
    output redirect_t out_redirect
);

    logic                 stage_valid;
    ex_mem_t              stage_instr;
    redirect_t            redirect;
    logic [WORD_SIZE-1:0] load_data;

    ////////////////////////////////////////////////////////////
    // Pipeline register and credits
    ////////////////////////////////////////////////////////////

    ex_mem_reg #(
        .WB_CREDITS (WB_CREDITS)
    ) u_ex_mem_reg (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .in_valid      (in_valid),
        .in_instr      (in_instr),
        .credit_return (credit_return),
        .in_ready      (in_ready),
        .stage_valid   (stage_valid),
        .stage_instr   (stage_instr)
    );

    // Branch and memory work side by side
    branch_resolve u_branch_resolve (
        .stage_valid (stage_valid),
        .stage_instr (stage_instr),
        .redirect    (redirect)
    );

    data_mem_access #(
        .MEM_WORDS (MEM_WORDS)
    ) u_data_mem_access (
        .clk         (clk),
        .stage_valid (stage_valid),
        .stage_instr (stage_instr),
        .load_data   (load_data)
    );

    // Writeback/redirect register
    mem_wb_out u_mem_wb_out (
        .clk          (clk),
        .rst          (rst),
        .stage_valid  (stage_valid),
        .stage_instr  (stage_instr),
        .redirect     (redirect),
        .load_data    (load_data),
        .out_valid    (out_valid),
        .out_wb       (out_wb),
        .out_redirect (out_redirect)
    );

endmodule

//--- test/mem_stage_props.sv
`timescale 1ns/1ps

// Bound into the stage top, credit counter seen through the register instance
module mem_stage_props #(
    parameter int WB_CREDITS = 4,
    parameter int CNT_W      = 3
) (
    input logic             clk,
    input logic             rst,
    input logic [CNT_W-1:0] credit_cnt,
    input logic             in_valid,
    input logic             in_ready,
    input logic             flush,
    input logic             out_valid
);

    logic accept;   // Handshake at the stage boundary

    assign accept = in_valid & in_ready & ~flush;

    ////////////////////////////////////////////////////////////
    // Credits
    ////////////////////////////////////////////////////////////

    a_credit_max: assert property (@(posedge clk) disable iff (rst)
        credit_cnt <= CNT_W'(WB_CREDITS))
        else $error("credit count above WB_CREDITS");

    a_ready_zero: assert property (@(posedge clk) disable iff (rst)
        (credit_cnt == '0) |-> !in_ready)
        else $error("in_ready high with no credit left");

    ////////////////////////////////////////////////////////////
    // Two edges from acceptance to out_valid
    ////////////////////////////////////////////////////////////

    // Unflushed acceptance must reach the output
    a_out_follows: assert property (@(posedge clk) disable iff (rst)
        accept ##1 !flush |=> out_valid)
        else $error("accepted instruction missing at the output two edges later");

    a_out_source: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $past(accept, 2) && !$past(flush))
        else $error("out_valid without an unflushed acceptance two edges earlier");

endmodule

bind mem_stage_top mem_stage_props #(
    .WB_CREDITS (WB_CREDITS),
    .CNT_W      ($clog2(WB_CREDITS + 1))
) u_props (
    .clk        (clk),
    .rst        (rst),
    .credit_cnt (u_ex_mem_reg.credit_cnt),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .flush      (flush),
    .out_valid  (out_valid)
);

//--- test/tb_mem_stage.sv
`timescale 1ns/1ps

module tb_mem_stage import mem_stage_pkg::*; ();

    localparam int MEM_WORDS    = 256;
    localparam int WB_CREDITS   = 4;
    localparam int RESET_CYCLES = 8;
    localparam int N_ROWS       = 25;
    localparam int N_HOLD       = 5;    // Flushed row plus four credit-draining rows
    localparam int TIMEOUT      = (N_ROWS + N_HOLD) * 12 + RESET_CYCLES;

    // One stimulus row with its expected writeback and redirect
    typedef struct packed {
        ex_mem_t              instr;
        logic                 flush;        // Discard while held in the stage register
        logic [WORD_SIZE-1:0] exp_data;
        logic                 exp_taken;
        logic [ADDR_SIZE-1:0] exp_target;
    } row_t;

    logic        clk;
    logic        rst;
    logic        flush;
    logic        in_valid;
    ex_mem_t     in_instr;
    logic        in_ready;
    logic        credit_return;
    logic        out_valid;
    wb_t         out_wb;
    redirect_t   out_redirect;

    row_t        rows [N_ROWS];
    row_t        expq [$];    // In flight, oldest first
    int          pend [$];    // Cycles at which consumed slots are handed back
    logic [31:0] lfsr;
    logic        hold;        // Writeback sits on its credits
    int          cycles;
    int          out_count;
    int          returned;

    mem_stage_top #(
        .MEM_WORDS  (MEM_WORDS),
        .WB_CREDITS (WB_CREDITS)
    ) u_dut (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .in_valid      (in_valid),
        .in_instr      (in_instr),
        .in_ready      (in_ready),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_wb        (out_wb),
        .out_redirect  (out_redirect)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;    // 20 ns period
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: run still busy after %0d cycles", TIMEOUT);
            $display("*** FAILED ***");
            $fatal(1);
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    // 0 to 7 cycles, three LFSR steps
    function automatic int pick_delay();
        logic [2:0] d;
        d = '0;
        repeat (3) begin
            d    = {d[1:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return int'(d);
    endfunction

    task automatic value_error(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        $display("** Error at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic plain_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    // Stores write back their address, nothing else
    function automatic row_t store_row(input logic [31:0] addr, input logic [31:0] data,
                                       input size_e size);
        row_t r;
        r                      = '0;
        r.instr.alu_result     = addr;
        r.instr.write_data     = data;
        r.instr.mem_write      = 1'b1;
        r.instr.data_size      = size;
        r.exp_data             = addr;
        return r;
    endfunction

    function automatic row_t load_row(input logic [4:0] rd, input logic [31:0] addr,
                                      input size_e size, input logic sign,
                                      input logic [31:0] exp);
        row_t r;
        r                      = '0;
        r.instr.rd             = rd;
        r.instr.alu_result     = addr;
        r.instr.mem_read       = 1'b1;
        r.instr.reg_write      = 1'b1;
        r.instr.data_sign      = sign;
        r.instr.data_size      = size;
        r.exp_data             = exp;
        return r;
    endfunction

    function automatic row_t alu_row(input logic [4:0] rd, input logic [31:0] result,
                                     input logic wr);
        row_t r;
        r                      = '0;
        r.instr.rd             = rd;
        r.instr.alu_result     = result;
        r.instr.reg_write      = wr;
        r.exp_data             = result;
        return r;
    endfunction

    // Taken only when the compare result was zero
    function automatic row_t branch_row(input logic [9:0] target, input logic zero,
                                        input logic [31:0] result);
        row_t r;
        r                      = '0;
        r.instr.branch         = 1'b1;
        r.instr.alu_zero       = zero;
        r.instr.alu_result     = result;
        r.instr.branch_target  = target;
        r.exp_data             = result;
        r.exp_taken            = zero;
        r.exp_target           = zero ? target : 10'h0;
        return r;
    endfunction

    function automatic row_t jump_row(input logic [4:0] rd, input logic [31:0] link,
                                      input logic [9:0] target);
        row_t r;
        r                      = alu_row(rd, link, 1'b1);
        r.instr.jump           = 1'b1;
        r.instr.branch_target  = target;
        r.exp_taken            = 1'b1;
        r.exp_target           = target;
        return r;
    endfunction

    task automatic build_table();
        rows[0]  = store_row(32'h40, 32'h8899AABB, SIZE_WORD);
        rows[1]  = load_row(5'd1, 32'h40, SIZE_WORD, 1'b0, 32'h8899AABB);
        rows[2]  = store_row(32'h41, 32'h777777CC, SIZE_BYTE);   // Lane 1 only
        rows[3]  = load_row(5'd2, 32'h40, SIZE_WORD, 1'b0, 32'h8899CCBB);
        rows[4]  = store_row(32'h42, 32'h1234F00D, SIZE_HALF);   // Upper half
        rows[5]  = load_row(5'd3, 32'h40, SIZE_WORD, 1'b0, 32'hF00DCCBB);
        rows[6]  = load_row(5'd4, 32'h41, SIZE_BYTE, 1'b1, 32'hFFFFFFCC);
        rows[7]  = load_row(5'd5, 32'h41, SIZE_BYTE, 1'b0, 32'h000000CC);
        rows[8]  = load_row(5'd6, 32'h42, SIZE_HALF, 1'b1, 32'hFFFFF00D);
        rows[9]  = load_row(5'd7, 32'h43, SIZE_HALF, 1'b0, 32'h0000F00D);  // Odd address
        rows[10] = load_row(5'd8, 32'h40, SIZE_BYTE, 1'b1, 32'hFFFFFFBB);
        rows[11] = load_row(5'd9, 32'h40, SIZE_HALF, 1'b1, 32'hFFFFCCBB);
        rows[12] = load_row(5'd10, 32'h440, SIZE_WORD, 1'b0, 32'hF00DCCBB);  // Wraps to 0x40
        rows[13] = alu_row(5'd11, 32'h12345678, 1'b1);
        rows[14] = alu_row(5'd12, 32'hDEADBEEF, 1'b0);
        rows[15] = branch_row(10'h2A4, 1'b1, 32'h0);
        rows[16] = branch_row(10'h155, 1'b0, 32'h5);
        rows[17] = jump_row(5'd1, 32'h104, 10'h3F0);
        rows[18] = store_row(32'h80, 32'h11223344, SIZE_WORD);
        rows[19] = store_row(32'h80, 32'hAAAAAAAA, SIZE_WORD);
        rows[19].flush = 1'b1;                                   // Must not reach the RAM
        rows[20] = load_row(5'd13, 32'h80, SIZE_WORD, 1'b0, 32'h11223344);
        rows[21] = store_row(32'h83, 32'hFFFFFF5A, SIZE_BYTE);
        rows[22] = load_row(5'd14, 32'h80, SIZE_WORD, 1'b0, 32'h5A223344);
        rows[23] = jump_row(5'd15, 32'h200, 10'h111);
        rows[23].flush = 1'b1;                                   // No redirect either
        rows[24] = load_row(5'd16, 32'h83, SIZE_BYTE, 1'b1, 32'h0000005A);
    endtask

    ////////////////////////////////////////////////////////////
    // Drive and drain
    ////////////////////////////////////////////////////////////

    // Strict rows must find a free credit without waiting
    task automatic apply_row(input row_t r, input logic strict);
        if (strict) begin
            assert (in_ready) else plain_error("in_ready low although a credit is free");
        end else begin
            while (!in_ready)
                @(negedge clk);
        end
        in_valid = 1'b1;
        in_instr = r.instr;
        if (!r.flush)
            expq.push_back(r);
        @(negedge clk);           // Taken at the rising edge just passed
        in_valid = 1'b0;
        if (r.flush) begin
            flush = 1'b1;         // Row now held in the stage register
            @(negedge clk);
            flush = 1'b0;
        end
    endtask

    task automatic wait_drained();
        @(negedge clk);
        while (expq.size() != 0 || pend.size() != 0 || credit_return)
            @(negedge clk);
    endtask

    task automatic check_output(input row_t e);
        assert (out_wb.data == e.exp_data)
            else value_error("writeback data", out_wb.data, e.exp_data);
        assert (out_wb.rd == e.instr.rd)
            else value_error("rd", 32'(out_wb.rd), 32'(e.instr.rd));
        assert (out_wb.reg_write == e.instr.reg_write)
            else value_error("reg_write", 32'(out_wb.reg_write), 32'(e.instr.reg_write));
        assert (out_redirect.taken == e.exp_taken)
            else value_error("redirect taken", 32'(out_redirect.taken), 32'(e.exp_taken));
        assert (out_redirect.target == e.exp_target)
            else value_error("redirect target", 32'(out_redirect.target), 32'(e.exp_target));
    endtask

    ////////////////////////////////////////////////////////////
    // Writeback stage model
    ////////////////////////////////////////////////////////////

    initial begin : consumer
        row_t e;
        int   due;
        credit_return = 1'b0;
        forever begin
            @(negedge clk);           // Outputs settled since the rising edge
            if (!rst) begin
                if (out_valid) begin
                    assert (expq.size() != 0)
                        else plain_error("out_valid with no instruction in flight");
                    e = expq.pop_front();
                    check_output(e);
                    out_count++;
                    assert (out_count <= returned + WB_CREDITS)
                        else plain_error("more outputs than returned credits allow");
                    due = cycles + pick_delay();
                    if (pend.size() != 0 && due <= pend[$])
                        due = pend[$] + 1;    // One pulse per cycle
                    pend.push_back(due);
                end
                credit_return = 1'b0;
                if (!hold && pend.size() != 0 && pend[0] <= cycles) begin
                    void'(pend.pop_front());
                    credit_return = 1'b1;
                    returned++;
                end
            end
        end
    end

    initial begin : stimulus
        row_t r;
        rst       = 1'b1;
        flush     = 1'b0;
        in_valid  = 1'b0;
        in_instr  = '0;
        hold      = 1'b0;
        lfsr      = 32'h8675bf85;
        cycles    = 0;
        out_count = 0;
        returned  = 0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < N_ROWS; i++)
            apply_row(rows[i], 1'b0);
        wait_drained();

        // Credits held back; flush refund leaves room for four more
        hold = 1'b1;
        for (int k = 0; k < N_HOLD; k++) begin
            r       = alu_row(5'(20 + k), 32'hC0DE0000 + 32'(k), 1'b1);
            r.flush = (k == 0);
            apply_row(r, 1'b1);
        end
        assert (!in_ready) else plain_error("in_ready still high with all credits in use");
        hold = 1'b0;
        wait_drained();

        $display("*** PASSED ***");
        $finish;
    end

endmodule

//--- project.f
source/mem_stage_pkg.sv
source/ex_mem_reg.sv
source/branch_resolve.sv
source/data_mem_access.sv
source/mem_wb_out.sv
source/mem_stage_top.sv
test/mem_stage_props.sv
test/tb_mem_stage.sv

//--- Makefile
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module tb_mem_stage -Mdir obj_dir -f project.f

run: build
	-./obj_dir/Vtb_mem_stage > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	elif ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing --top-module mem_stage_top -f project.f

clean:
	rm -rf obj_dir $(LOG)
